/* Bender.yml */
package:
  name: hdcpu_ctrl

sources:
  - files:
      - rtl/hdcpu_pkg.sv
      - rtl/ctrl_word_if.sv
      - rtl/console_seq.sv
      - rtl/instr_exec.sv
      - rtl/mode_sequencer.sv
      - rtl/hdcpu_ctrl.sv
  - target: test
    files:
      - test/ctrl_checker.sv
      - test/tb_hdcpu_ctrl.sv

/* hdcpu_ctrl.f */
rtl/hdcpu_pkg.sv
rtl/ctrl_word_if.sv
rtl/console_seq.sv
rtl/instr_exec.sv
rtl/mode_sequencer.sv
rtl/hdcpu_ctrl.sv
test/ctrl_checker.sv
test/tb_hdcpu_ctrl.sv

/* rtl/console_seq.sv */
`timescale 1ns/1ns

module console_seq (
    input  logic [2:0]         sw,
    input  logic [3:1]         w,
    input  logic               st0,
    ctrl_word_if.source        word
);

    always_comb begin
        word.ldc     = 1'b0;
        word.ldz     = 1'b0;
        word.cin     = 1'b0;
        word.m       = 1'b0;
        word.abus    = 1'b0;
        word.drw     = 1'b0;
        word.pcinc   = 1'b0;
        word.lpc     = 1'b0;
        word.lar     = 1'b0;
        word.pcadd   = 1'b0;
        word.arinc   = 1'b0;
        word.selctl  = 1'b0;
        word.memw    = 1'b0;
        word.stop    = 1'b0;
        word.lir     = 1'b0;
        word.sbus    = 1'b0;
        word.mbus    = 1'b0;
        word.short   = 1'b0;
        word.long    = 1'b0;
        word.s       = hdcpu_pkg::ALU_ZERO;
        word.sel     = hdcpu_pkg::SEL_NONE;
        word.set_st0 = 1'b0;

        case (sw)
            hdcpu_pkg::MODE_MEM_WR: begin
                // First pass loads AR from switches, later passes write and step
                word.lar     = w[1] && !st0;
                word.memw    = w[1] && st0;
                word.arinc   = w[1] && st0;
                word.sbus    = w[1];
                word.stop    = w[1];
                word.short   = w[1];
                word.selctl  = w[1];
                word.set_st0 = w[1];
            end
            hdcpu_pkg::MODE_MEM_RD: begin
                word.sbus    = w[1] && !st0;
                word.lar     = w[1] && !st0;
                word.set_st0 = w[1] && !st0;
                word.mbus    = w[1] && st0;
                word.arinc   = w[1] && st0;
                word.stop    = w[1];
                word.short   = w[1];
                word.selctl  = w[1];
            end
            hdcpu_pkg::MODE_REG_RD: begin
                word.selctl = w[1] || w[2];
                word.stop   = w[1] || w[2];
                word.sel    = {w[2], 1'b0, w[2], w[1] || w[2]}; // R0/R1 then R2/R3
            end
            hdcpu_pkg::MODE_REG_WR: begin
                word.sbus    = w[1] || w[2];
                word.selctl  = w[1] || w[2];
                word.drw     = w[1] || w[2];
                word.stop    = w[1] || w[2];
                word.set_st0 = w[2] && !st0;
                // R0,R1 on the first pass, R2,R3 on the second
                word.sel[3]  = st0;
                word.sel[2]  = w[2];
                word.sel[1]  = (w[1] && !st0) || (w[2] && st0);
                word.sel[0]  = w[1];
            end
            default: begin
                // Run mode and spare codes leave the word idle
            end
        endcase
    end

endmodule

/* rtl/ctrl_word_if.sv */
`timescale 1ns/1ns

interface ctrl_word_if;

    logic ldc;
    logic ldz;
    logic cin;
    logic m;
    logic abus;
    logic drw;
    logic pcinc;
    logic lpc;
    logic lar;
    logic pcadd;
    logic arinc;
    logic selctl;
    logic memw;
    logic stop;
    logic lir;
    logic sbus;
    logic mbus;
    logic short;
    logic long;
    logic [hdcpu_pkg::ALU_FN_W-1:0] s;
    logic [hdcpu_pkg::SEL_W-1:0]    sel;
    logic set_st0; // Request to raise st0 on the next t3 fall

    modport source (
        output ldc, ldz, cin, m, abus, drw, pcinc, lpc, lar, pcadd, arinc,
        output selctl, memw, stop, lir, sbus, mbus, short, long,
        output s, sel, set_st0
    );

    modport sink (
        input ldc, ldz, cin, m, abus, drw, pcinc, lpc, lar, pcadd, arinc,
        input selctl, memw, stop, lir, sbus, mbus, short, long,
        input s, sel, set_st0
    );

endinterface

/* rtl/hdcpu_ctrl.sv */
`timescale 1ns/1ns

module hdcpu_ctrl (
    input  logic                           t3,
    input  logic                           rst_n,
    input  logic                           c,
    input  logic                           z,
    input  logic [2:0]                     sw,
    input  logic [3:0]                     ir_op,
    input  logic [3:1]                     w,
    output logic                           ldc,
    output logic                           ldz,
    output logic                           cin,
    output logic                           m,
    output logic                           abus,
    output logic                           drw,
    output logic                           pcinc,
    output logic                           lpc,
    output logic                           lar,
    output logic                           pcadd,
    output logic                           arinc,
    output logic                           selctl,
    output logic                           memw,
    output logic                           stop,
    output logic                           lir,
    output logic                           sbus,
    output logic                           mbus,
    output logic                           short,
    output logic                           long,
    output logic [hdcpu_pkg::ALU_FN_W-1:0] s,
    output logic [hdcpu_pkg::SEL_W-1:0]    sel
);

    logic st0;

    ctrl_word_if con_word ();
    ctrl_word_if exec_word ();

    console_seq u_console_seq (
        .sw   (sw),
        .w    (w),
        .st0  (st0),
        .word (con_word)
    );

    instr_exec u_instr_exec (
        .ir_op (ir_op),
        .w     (w),
        .st0   (st0),
        .c     (c),
        .z     (z),
        .word  (exec_word)
    );

    mode_sequencer u_mode_sequencer (
        .t3        (t3),
        .rst_n     (rst_n),
        .sw        (sw),
        .w         (w),
        .con_word  (con_word),
        .exec_word (exec_word),
        .st0       (st0),
        .ldc       (ldc),
        .ldz       (ldz),
        .cin       (cin),
        .m         (m),
        .abus      (abus),
        .drw       (drw),
        .pcinc     (pcinc),
        .lpc       (lpc),
        .lar       (lar),
        .pcadd     (pcadd),
        .arinc     (arinc),
        .selctl    (selctl),
        .memw      (memw),
        .stop      (stop),
        .lir       (lir),
        .sbus      (sbus),
        .mbus      (mbus),
        .short     (short),
        .long      (long),
        .s         (s),
        .sel       (sel)
    );

endmodule

/* rtl/hdcpu_pkg.sv */
package hdcpu_pkg;

    // Port widths
    localparam int ALU_FN_W = 4;
    localparam int SEL_W    = 4;

    // Console switch modes
    localparam logic [2:0] MODE_RUN    = 3'b000;
    localparam logic [2:0] MODE_MEM_WR = 3'b001;
    localparam logic [2:0] MODE_MEM_RD = 3'b010;
    localparam logic [2:0] MODE_REG_RD = 3'b011;
    localparam logic [2:0] MODE_REG_WR = 3'b100;

    // Opcodes from IR[7:4]
    localparam logic [3:0] OP_NOP = 4'b0000;
    localparam logic [3:0] OP_ADD = 4'b0001;
    localparam logic [3:0] OP_SUB = 4'b0010;
    localparam logic [3:0] OP_AND = 4'b0011;
    localparam logic [3:0] OP_INC = 4'b0100;
    localparam logic [3:0] OP_LD  = 4'b0101;
    localparam logic [3:0] OP_ST  = 4'b0110;
    localparam logic [3:0] OP_JC  = 4'b0111;
    localparam logic [3:0] OP_JZ  = 4'b1000;
    localparam logic [3:0] OP_JMP = 4'b1001;
    localparam logic [3:0] OP_OUT = 4'b1010;
    localparam logic [3:0] OP_OR  = 4'b1100;
    localparam logic [3:0] OP_XOR = 4'b1101;
    localparam logic [3:0] OP_STP = 4'b1110;
    // 1011 and 1111 are unassigned and decode as NOP

    // ALU function select on S[3:0]
    localparam logic [ALU_FN_W-1:0] ALU_ADD    = 4'b1001;
    localparam logic [ALU_FN_W-1:0] ALU_SUB    = 4'b0110;
    localparam logic [ALU_FN_W-1:0] ALU_AND    = 4'b1011;
    localparam logic [ALU_FN_W-1:0] ALU_OR     = 4'b1110;
    localparam logic [ALU_FN_W-1:0] ALU_XOR    = 4'b0110; // Logic mode with M high
    localparam logic [ALU_FN_W-1:0] ALU_PASS_A = 4'b1010;
    localparam logic [ALU_FN_W-1:0] ALU_ONES   = 4'b1111;
    localparam logic [ALU_FN_W-1:0] ALU_ZERO   = 4'b0000;

    // Register select as destination pair then source pair
    localparam logic [SEL_W-1:0] SEL_R3_R3 = 4'b1111;
    localparam logic [SEL_W-1:0] SEL_NONE  = 4'b0000;

endpackage

/* rtl/instr_exec.sv */
`timescale 1ns/1ns

module instr_exec (
    input  logic [3:0]         ir_op,
    input  logic [3:1]         w,
    input  logic               st0,
    input  logic               c,
    input  logic               z,
    ctrl_word_if.source        word
);

    always_comb begin
        word.ldc     = 1'b0;
        word.ldz     = 1'b0;
        word.cin     = 1'b0;
        word.m       = 1'b0;
        word.abus    = 1'b0;
        word.drw     = 1'b0;
        word.pcinc   = 1'b0;
        word.lpc     = 1'b0;
        word.lar     = 1'b0;
        word.pcadd   = 1'b0;
        word.arinc   = 1'b0;
        word.selctl  = 1'b0;
        word.memw    = 1'b0;
        word.stop    = 1'b0;
        word.lir     = 1'b0;
        word.sbus    = 1'b0;
        word.mbus    = 1'b0;
        word.short   = 1'b0;
        word.long    = 1'b0;
        word.s       = hdcpu_pkg::ALU_ZERO;
        word.sel     = hdcpu_pkg::SEL_NONE;
        word.set_st0 = 1'b0;

        if (!st0) begin
            // Program start moves the switches into R3 and then R3 into PC
            word.selctl  = 1'b1;
            word.sel     = hdcpu_pkg::SEL_R3_R3;
            word.s       = hdcpu_pkg::ALU_PASS_A;
            word.sbus    = w[1];
            word.drw     = w[1];
            word.stop    = w[1];
            word.abus    = w[2];
            word.m       = w[2];
            word.lpc     = w[2];
            word.set_st0 = w[2];
        end else if (w[1]) begin
            word.lir   = 1'b1; // Fetch
            word.pcinc = 1'b1;
        end else if (w[2]) begin
            case (ir_op)
                hdcpu_pkg::OP_ADD, hdcpu_pkg::OP_SUB: begin
                    word.s    = (ir_op == hdcpu_pkg::OP_ADD) ? hdcpu_pkg::ALU_ADD
                                                             : hdcpu_pkg::ALU_SUB;
                    word.cin  = (ir_op == hdcpu_pkg::OP_ADD);
                    word.abus = 1'b1;
                    word.drw  = 1'b1;
                    word.ldz  = 1'b1;
                    word.ldc  = 1'b1;
                end
                hdcpu_pkg::OP_INC: begin
                    word.s    = hdcpu_pkg::ALU_ZERO; // A plus one with carry-in low
                    word.abus = 1'b1;
                    word.drw  = 1'b1;
                    word.ldz  = 1'b1;
                    word.ldc  = 1'b1;
                end
                hdcpu_pkg::OP_AND, hdcpu_pkg::OP_OR, hdcpu_pkg::OP_XOR: begin
                    case (ir_op)
                        hdcpu_pkg::OP_AND: word.s = hdcpu_pkg::ALU_AND;
                        hdcpu_pkg::OP_OR:  word.s = hdcpu_pkg::ALU_OR;
                        default:           word.s = hdcpu_pkg::ALU_XOR;
                    endcase
                    word.m    = 1'b1;
                    word.abus = 1'b1;
                    word.drw  = 1'b1;
                    word.ldz  = 1'b1;
                end
                hdcpu_pkg::OP_LD: begin
                    word.s    = hdcpu_pkg::ALU_PASS_A; // Address from source reg
                    word.m    = 1'b1;
                    word.abus = 1'b1;
                    word.lar  = 1'b1;
                    word.long = 1'b1;
                end
                hdcpu_pkg::OP_ST: begin
                    word.s    = hdcpu_pkg::ALU_ONES; // Address from dest reg
                    word.m    = 1'b1;
                    word.abus = 1'b1;
                    word.lar  = 1'b1;
                    word.long = 1'b1;
                end
                hdcpu_pkg::OP_JC: word.pcadd = c;
                hdcpu_pkg::OP_JZ: word.pcadd = z;
                hdcpu_pkg::OP_JMP: begin
                    word.s    = hdcpu_pkg::ALU_ONES;
                    word.m    = 1'b1;
                    word.abus = 1'b1;
                    word.lpc  = 1'b1;
                end
                hdcpu_pkg::OP_OUT: begin
                    word.s    = hdcpu_pkg::ALU_PASS_A;
                    word.m    = 1'b1;
                    word.abus = 1'b1;
                end
                hdcpu_pkg::OP_STP: word.stop = 1'b1;
                hdcpu_pkg::OP_NOP: begin
                end
                default: begin
                end
            endcase
        end else if (w[3]) begin
            // Only the memory instructions use the long beat
            case (ir_op)
                hdcpu_pkg::OP_LD: begin
                    word.drw  = 1'b1;
                    word.mbus = 1'b1;
                end
                hdcpu_pkg::OP_ST: begin
                    word.s    = hdcpu_pkg::ALU_PASS_A; // Data from source reg
                    word.m    = 1'b1;
                    word.abus = 1'b1;
                    word.memw = 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

/* rtl/mode_sequencer.sv */
`timescale 1ns/1ns

module mode_sequencer (
    input  logic                           t3,
    input  logic                           rst_n,
    input  logic [2:0]                     sw,
    input  logic [3:1]                     w,
    ctrl_word_if.sink                      con_word,
    ctrl_word_if.sink                      exec_word,
    output logic                           st0,
    output logic                           ldc,
    output logic                           ldz,
    output logic                           cin,
    output logic                           m,
    output logic                           abus,
    output logic                           drw,
    output logic                           pcinc,
    output logic                           lpc,
    output logic                           lar,
    output logic                           pcadd,
    output logic                           arinc,
    output logic                           selctl,
    output logic                           memw,
    output logic                           stop,
    output logic                           lir,
    output logic                           sbus,
    output logic                           mbus,
    output logic                           short,
    output logic                           long,
    output logic [hdcpu_pkg::ALU_FN_W-1:0] s,
    output logic [hdcpu_pkg::SEL_W-1:0]    sel
);

    localparam int WORD_W = 19 + hdcpu_pkg::ALU_FN_W + hdcpu_pkg::SEL_W;

    logic [WORD_W-1:0] con_bits;
    logic [WORD_W-1:0] exec_bits;
    logic [WORD_W-1:0] act_bits;
    logic              run_mode;
    logic              set_st0;

    assign con_bits = {con_word.ldc, con_word.ldz, con_word.cin, con_word.m,
                       con_word.abus, con_word.drw, con_word.pcinc, con_word.lpc,
                       con_word.lar, con_word.pcadd, con_word.arinc, con_word.selctl,
                       con_word.memw, con_word.stop, con_word.lir, con_word.sbus,
                       con_word.mbus, con_word.short, con_word.long,
                       con_word.s, con_word.sel};

    assign exec_bits = {exec_word.ldc, exec_word.ldz, exec_word.cin, exec_word.m,
                        exec_word.abus, exec_word.drw, exec_word.pcinc, exec_word.lpc,
                        exec_word.lar, exec_word.pcadd, exec_word.arinc, exec_word.selctl,
                        exec_word.memw, exec_word.stop, exec_word.lir, exec_word.sbus,
                        exec_word.mbus, exec_word.short, exec_word.long,
                        exec_word.s, exec_word.sel};

    assign run_mode = (sw == hdcpu_pkg::MODE_RUN);
    assign act_bits = run_mode ? exec_bits : con_bits;
    assign set_st0  = run_mode ? exec_word.set_st0 : con_word.set_st0;

    // Datapath sees an idle word while the unit is held in reset
    assign {ldc, ldz, cin, m, abus, drw, pcinc, lpc, lar, pcadd, arinc, selctl,
            memw, stop, lir, sbus, mbus, short, long, s, sel} =
           rst_n ? act_bits : '0;

    always_ff @(negedge t3 or negedge rst_n) begin
        if (!rst_n) begin
            st0 <= 1'b0;
        end else if (set_st0) begin
            st0 <= 1'b1;
        end else if (sw == hdcpu_pkg::MODE_REG_WR && st0 && w[2]) begin
            st0 <= 1'b0; // End of the second register-write pass
        end
    end

endmodule

/* test/ctrl_checker.sv */
`timescale 1ns/1ns

module ctrl_checker (
    input logic       t3,
    input logic       rst_n,
    input logic       c,
    input logic       z,
    input logic [2:0] sw,
    input logic [3:0] ir_op,
    input logic [3:1] w,
    input logic       ldc, ldz, cin, m, abus, drw, pcinc, lpc, lar, pcadd,
    input logic       arinc, selctl, memw, stop, lir, sbus, mbus, short, long,
    input logic [3:0] s,
    input logic [3:0] sel
);

    int   checks     = 0;
    int   mismatches = 0;
    logic st0_m      = 1'b0; // Model of the start state
    logic set_m;
    logic e_ldc, e_ldz, e_cin, e_m, e_abus, e_drw, e_pcinc, e_lpc, e_lar, e_pcadd;
    logic e_arinc, e_selctl, e_memw, e_stop, e_lir, e_sbus, e_mbus, e_short, e_long;
    logic [3:0] e_s;
    logic [3:0] e_sel;

    task automatic build_expected();
        {e_ldc, e_ldz, e_cin, e_m, e_abus, e_drw, e_pcinc, e_lpc, e_lar, e_pcadd,
         e_arinc, e_selctl, e_memw, e_stop, e_lir, e_sbus, e_mbus, e_short, e_long,
         e_s, e_sel, set_m} = '0;
        if (rst_n === 1'b1) begin
            if (sw == hdcpu_pkg::MODE_MEM_WR && w[1]) begin
                {e_sbus, e_stop, e_short, e_selctl, set_m} = 5'b11111;
                e_lar   = !st0_m;
                e_memw  = st0_m;
                e_arinc = st0_m;
            end else if (sw == hdcpu_pkg::MODE_MEM_RD && w[1]) begin
                {e_stop, e_short, e_selctl} = 3'b111;
                {e_sbus, e_lar, set_m} = {3{!st0_m}};
                {e_mbus, e_arinc} = {2{st0_m}};
            end else if (sw == hdcpu_pkg::MODE_REG_RD) begin
                {e_selctl, e_stop} = {2{w[1] | w[2]}};
                e_sel = {w[2], 1'b0, w[2], w[1] | w[2]};
            end else if (sw == hdcpu_pkg::MODE_REG_WR) begin
                {e_sbus, e_selctl, e_drw, e_stop} = {4{w[1] | w[2]}};
                set_m = w[2] & !st0_m;
                e_sel = {st0_m, w[2], (w[1] & !st0_m) | (w[2] & st0_m), w[1]};
            end else if (sw == hdcpu_pkg::MODE_RUN && !st0_m) begin
                e_selctl = 1'b1; // Program start
                e_sel    = hdcpu_pkg::SEL_R3_R3;
                e_s      = hdcpu_pkg::ALU_PASS_A;
                {e_sbus, e_drw, e_stop} = {3{w[1]}};
                {e_abus, e_m, e_lpc, set_m} = {4{w[2]}};
            end else if (sw == hdcpu_pkg::MODE_RUN && w[1]) begin
                {e_lir, e_pcinc} = 2'b11;
            end else if (sw == hdcpu_pkg::MODE_RUN && w[2]) begin
                case (ir_op)
                    hdcpu_pkg::OP_ADD: {e_s, e_cin, e_abus, e_drw, e_ldz, e_ldc} =
                        {hdcpu_pkg::ALU_ADD, 5'b11111};
                    hdcpu_pkg::OP_SUB: {e_s, e_cin, e_abus, e_drw, e_ldz, e_ldc} =
                        {hdcpu_pkg::ALU_SUB, 5'b01111};
                    hdcpu_pkg::OP_INC: {e_s, e_abus, e_drw, e_ldz, e_ldc} =
                        {hdcpu_pkg::ALU_ZERO, 4'b1111};
                    hdcpu_pkg::OP_AND: {e_s, e_m, e_abus, e_drw, e_ldz} =
                        {hdcpu_pkg::ALU_AND, 4'b1111};
                    hdcpu_pkg::OP_OR: {e_s, e_m, e_abus, e_drw, e_ldz} =
                        {hdcpu_pkg::ALU_OR, 4'b1111};
                    hdcpu_pkg::OP_XOR: {e_s, e_m, e_abus, e_drw, e_ldz} =
                        {hdcpu_pkg::ALU_XOR, 4'b1111};
                    hdcpu_pkg::OP_LD: {e_s, e_m, e_abus, e_lar, e_long} =
                        {hdcpu_pkg::ALU_PASS_A, 4'b1111};
                    hdcpu_pkg::OP_ST: {e_s, e_m, e_abus, e_lar, e_long} =
                        {hdcpu_pkg::ALU_ONES, 4'b1111};
                    hdcpu_pkg::OP_JC: e_pcadd = c;
                    hdcpu_pkg::OP_JZ: e_pcadd = z;
                    hdcpu_pkg::OP_JMP: {e_s, e_m, e_abus, e_lpc} =
                        {hdcpu_pkg::ALU_ONES, 3'b111};
                    hdcpu_pkg::OP_OUT: {e_s, e_m, e_abus} = {hdcpu_pkg::ALU_PASS_A, 2'b11};
                    hdcpu_pkg::OP_STP: e_stop = 1'b1;
                    default: ; // NOP and unassigned codes
                endcase
            end else if (sw == hdcpu_pkg::MODE_RUN && w[3]) begin
                if (ir_op == hdcpu_pkg::OP_LD) begin
                    {e_drw, e_mbus} = 2'b11;
                end else if (ir_op == hdcpu_pkg::OP_ST) begin
                    {e_s, e_m, e_abus, e_memw} = {hdcpu_pkg::ALU_PASS_A, 3'b111};
                end
            end
        end
    endtask

    task automatic compare(input string name, input logic [3:0] exp, input logic [3:0] act);
        checks++;
        if (act !== exp) begin
            mismatches++;
            $display("MISMATCH %s expected %h actual %h (sw=%h op=%h w=%h st0=%h) at %0t",
                     name, exp, act, sw, ir_op, w, st0_m, $time);
        end
    endtask

    // Outputs settle well before the falling edge
    always @(posedge t3) begin
        #4;
        build_expected();
        compare("ldc", e_ldc, ldc);
        compare("ldz", e_ldz, ldz);
        compare("cin", e_cin, cin);
        compare("m", e_m, m);
        compare("abus", e_abus, abus);
        compare("drw", e_drw, drw);
        compare("pcinc", e_pcinc, pcinc);
        compare("lpc", e_lpc, lpc);
        compare("lar", e_lar, lar);
        compare("pcadd", e_pcadd, pcadd);
        compare("arinc", e_arinc, arinc);
        compare("selctl", e_selctl, selctl);
        compare("memw", e_memw, memw);
        compare("stop", e_stop, stop);
        compare("lir", e_lir, lir);
        compare("sbus", e_sbus, sbus);
        compare("mbus", e_mbus, mbus);
        compare("short", e_short, short);
        compare("long", e_long, long);
        compare("s", e_s, s);
        compare("sel", e_sel, sel);
    end

    always @(negedge t3) begin
        build_expected();
        if (rst_n !== 1'b1) begin
            st0_m = 1'b0;
        end else if (set_m) begin
            st0_m = 1'b1;
        end else if (sw == hdcpu_pkg::MODE_REG_WR && st0_m && w[2]) begin
            st0_m = 1'b0; // Second register-write pass done
        end
    end

endmodule

/* test/tb_hdcpu_ctrl.sv */
`timescale 1ns/1ns

module tb_hdcpu_ctrl;

    localparam int N_CYCLES = 3000;
    localparam int PERIOD   = 10;

    integer     seed  = 32'hf52e;
    logic       t3    = 1'b0;
    logic       rst_n = 1'b0;
    logic       c     = 1'b0;
    logic       z     = 1'b0;
    logic [2:0] sw    = hdcpu_pkg::MODE_RUN;
    logic [3:0] ir_op = 4'h0;
    logic [3:1] w     = 3'b001;
    logic       ldc, ldz, cin, m, abus, drw, pcinc, lpc, lar, pcadd;
    logic       arinc, selctl, memw, stop, lir, sbus, mbus, short, long;
    logic [3:0] s;
    logic [3:0] sel;

    hdcpu_ctrl uut (.*);

    ctrl_checker chk (.*);

    initial begin
        forever #(PERIOD / 2) t3 = ~t3;
    end

    task automatic drive_random();
        int r;
        r = {$random(seed)} % 4;
        if (r == 0) begin // Modes last a few beats
            r = {$random(seed)} % 8;
            sw = (r < 5) ? 3'(r) : hdcpu_pkg::MODE_RUN; // Extra weight on run
        end
        ir_op = $random(seed);
        c     = $random(seed);
        z     = $random(seed);
        w     = 3'b001 << ({$random(seed)} % 3);
    endtask

    initial begin
        repeat (2) begin
            @(posedge t3);
            #1;
            drive_random();
        end
        rst_n = 1'b1;
        repeat (N_CYCLES) begin
            @(posedge t3);
            #1;
            drive_random();
        end
        @(negedge t3);
        #1;
        $display("Checks: %0d, mismatches: %0d", chk.checks, chk.mismatches);
        if (chk.mismatches == 0 && chk.checks > 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        #(N_CYCLES * PERIOD + 200);
        $display("Timeout: the stimulus did not finish within %0d ns",
                 N_CYCLES * PERIOD + 200);
        $display("*** FAILED ***");
        $finish;
    end

endmodule
